// File: design/cpu_params.svh
// CPU configuration macros
// Word width, register file size, memory depths and opcode field width
// for the five-stage pipelined core
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// One data or instruction word
`define CPU_DATA_W 16

// General purpose registers
`define CPU_REG_CNT 8

// Instruction and data memory sizes in words
`define CPU_IMEM_DEPTH 256
`define CPU_DMEM_DEPTH 256

// Opcode field in instr[15:11]
`define CPU_OPC_W 5

`endif

// File: design/cpu_pkg.sv
// Shared types for the pipelined CPU
// Word and register index types, instruction opcodes and the ALU
// operations selected by decode
`default_nettype none
`include "cpu_params.svh"

package cpu_pkg;

   typedef logic [`CPU_DATA_W-1:0] word_t;
   typedef logic [$clog2(`CPU_REG_CNT)-1:0] reg_idx_t;

   // Any code not listed here is illegal
   // R-type codes 110xx carry the ALU operation in their low bits
   typedef enum logic [`CPU_OPC_W-1:0] {
      OPC_HALT = 5'b00000,
      OPC_NOP  = 5'b00001,
      OPC_J    = 5'b00100,
      OPC_ADDI = 5'b01000,
      OPC_BEQZ = 5'b01100,
      OPC_BNEZ = 5'b01101,
      OPC_ST   = 5'b10000,
      OPC_LD   = 5'b10001,
      OPC_ADD  = 5'b11000,
      OPC_SUB  = 5'b11001,
      OPC_AND  = 5'b11010,
      OPC_XOR  = 5'b11011
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_ADD    = 3'd0,
      ALU_SUB    = 3'd1,
      ALU_AND    = 3'd2,
      ALU_XOR    = 3'd3,
      ALU_PASS_A = 3'd4
   } alu_op_e;

endpackage
`default_nettype wire

// File: design/fetch.sv
// Instruction fetch stage
// Holds the PC and the instruction memory. The memory is written through
// the load port while the core is stopped; once running, one instruction
// per cycle enters the fetch/decode register
`default_nettype none
`include "cpu_params.svh"

module fetch (
   input  wire                                 clk,
   input  wire                                 arst_n,
   input  wire                                 run,
   input  wire                                 load_en,
   input  wire [$clog2(`CPU_IMEM_DEPTH)-1:0]   load_addr,
   input  wire cpu_pkg::word_t                 load_data,
   input  wire                                 stall,
   input  wire                                 halt_seen,
   input  wire                                 redirect,
   input  wire cpu_pkg::word_t                 redirect_pc,
   output logic                                fd_valid,
   output cpu_pkg::word_t                      fd_instr,
   output cpu_pkg::word_t                      fd_pc_next
);

   localparam int IMEM_AW = $clog2(`CPU_IMEM_DEPTH);

   cpu_pkg::word_t imem [`CPU_IMEM_DEPTH];
   cpu_pkg::word_t pc;
   cpu_pkg::word_t pc_plus2;
   logic           advance;

   assign pc_plus2 = pc + cpu_pkg::word_t'(2);

   // A new instruction is taken only when nothing holds or kills fetch
   assign advance = run && !redirect && !halt_seen && !stall;

   // Load port, honored only while stopped
   always_ff @(posedge clk) begin
      if (load_en && !run) begin
         imem[load_addr] <= load_data;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pc       <= '0;
         fd_valid <= 1'b0;
      end else if (!run) begin
         pc       <= '0;
         fd_valid <= 1'b0;
      end else if (redirect) begin
         pc       <= redirect_pc;
         fd_valid <= 1'b0;
      end else if (halt_seen) begin
         // PC frozen for good
         fd_valid <= 1'b0;
      end else if (!stall) begin
         pc       <= pc_plus2;
         fd_valid <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         fd_instr   <= imem[pc[IMEM_AW:1]];
         fd_pc_next <= pc_plus2;
      end
   end

endmodule
`default_nettype wire

// File: design/decode.sv
// Instruction decode stage
// Turns the opcode into control, reads the register file with write-through
// from writeback, sign-extends the immediate and registers the
// decode/execute bundle. Also tracks HALT and the sticky illegal-opcode error
`default_nettype none
`include "cpu_params.svh"

module decode (
   input  wire                     clk,
   input  wire                     arst_n,
   input  wire                     redirect,
   input  wire                     stall,
   input  wire                     fd_valid,
   input  wire cpu_pkg::word_t     fd_instr,
   input  wire cpu_pkg::word_t     fd_pc_next,
   input  wire                     wb_en,
   input  wire cpu_pkg::reg_idx_t  wb_reg,
   input  wire cpu_pkg::word_t     wb_data,
   output cpu_pkg::reg_idx_t       rs,
   output cpu_pkg::reg_idx_t       rt,
   output logic                    use_rs,
   output logic                    use_rt,
   output logic                    halt_seen,
   output logic                    err,
   output logic                    de_valid,
   output cpu_pkg::alu_op_e        de_alu_op,
   output logic                    de_use_imm,
   output cpu_pkg::word_t          de_a,
   output cpu_pkg::word_t          de_b,
   output cpu_pkg::word_t          de_imm,
   output cpu_pkg::word_t          de_pc_next,
   output logic                    de_wr_en,
   output cpu_pkg::reg_idx_t       de_wr_reg,
   output logic                    de_mem_rd,
   output logic                    de_mem_wr,
   output cpu_pkg::opcode_e        de_branch_kind,
   output logic                    de_halt
);

   cpu_pkg::word_t    rf [`CPU_REG_CNT];
   cpu_pkg::word_t    rd_a;
   cpu_pkg::word_t    rd_b;
   cpu_pkg::word_t    imm;
   cpu_pkg::opcode_e  opc;
   cpu_pkg::opcode_e  branch_kind;
   cpu_pkg::alu_op_e  alu_op;
   cpu_pkg::reg_idx_t wr_reg;
   logic              need_rs;
   logic              need_rt;
   logic              use_imm;
   logic              wr_en;
   logic              mem_rd;
   logic              mem_wr;
   logic              is_halt;
   logic              illegal;
   logic              take;
   logic              halt_q;

   assign opc    = cpu_pkg::opcode_e'(fd_instr[15:11]);
   assign rs     = fd_instr[10:8];
   assign rt     = fd_instr[7:5];
   assign use_rs = fd_valid && need_rs;
   assign use_rt = fd_valid && need_rt;

   always_comb begin
      alu_op      = cpu_pkg::ALU_PASS_A;
      branch_kind = cpu_pkg::OPC_NOP;
      imm         = cpu_pkg::word_t'($signed(fd_instr[4:0]));
      wr_reg      = fd_instr[7:5];
      need_rs     = 1'b0;
      need_rt     = 1'b0;
      use_imm     = 1'b0;
      wr_en       = 1'b0;
      mem_rd      = 1'b0;
      mem_wr      = 1'b0;
      is_halt     = 1'b0;
      illegal     = 1'b0;
      case (opc)
         cpu_pkg::OPC_ADD,
         cpu_pkg::OPC_SUB,
         cpu_pkg::OPC_AND,
         cpu_pkg::OPC_XOR: begin
            // rd = rs op rt, op taken from the opcode's low bits
            alu_op  = cpu_pkg::alu_op_e'({1'b0, fd_instr[12:11]});
            need_rs = 1'b1;
            need_rt = 1'b1;
            wr_en   = 1'b1;
            wr_reg  = fd_instr[4:2];
         end
         cpu_pkg::OPC_ADDI,
         cpu_pkg::OPC_LD,
         cpu_pkg::OPC_ST: begin
            // Address or sum is rs + imm5, ST stores rt
            alu_op  = cpu_pkg::ALU_ADD;
            use_imm = 1'b1;
            need_rs = 1'b1;
            need_rt = (opc == cpu_pkg::OPC_ST);
            wr_en   = (opc != cpu_pkg::OPC_ST);
            mem_rd  = (opc == cpu_pkg::OPC_LD);
            mem_wr  = (opc == cpu_pkg::OPC_ST);
         end
         cpu_pkg::OPC_BEQZ,
         cpu_pkg::OPC_BNEZ: begin
            need_rs     = 1'b1;
            imm         = cpu_pkg::word_t'($signed(fd_instr[7:0]));
            branch_kind = opc;
         end
         cpu_pkg::OPC_J: begin
            imm         = cpu_pkg::word_t'($signed(fd_instr[10:0]));
            branch_kind = opc;
         end
         cpu_pkg::OPC_NOP: begin
         end
         cpu_pkg::OPC_HALT: is_halt = 1'b1;
         default:           illegal = 1'b1;
      endcase
   end

   // Write-through so a same-cycle writeback is seen by the reader
   assign rd_a = (wb_en && wb_reg == rs) ? wb_data : rf[rs];
   assign rd_b = (wb_en && wb_reg == rt) ? wb_data : rf[rt];

   always_ff @(posedge clk) begin
      if (wb_en) begin
         rf[wb_reg] <= wb_data;
      end
   end

   assign take      = fd_valid && !stall && !redirect;
   assign halt_seen = halt_q || (fd_valid && !redirect && (is_halt || illegal));

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         halt_q <= 1'b0;
         err    <= 1'b0;
      end else if (take) begin
         if (is_halt || illegal) begin
            halt_q <= 1'b1;
         end
         if (illegal) begin
            err <= 1'b1;
         end
      end
   end

   // Bubble on stall, redirect or empty input
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         de_valid       <= 1'b0;
         de_wr_en       <= 1'b0;
         de_mem_rd      <= 1'b0;
         de_mem_wr      <= 1'b0;
         de_halt        <= 1'b0;
         de_branch_kind <= cpu_pkg::OPC_NOP;
      end else begin
         de_valid       <= take;
         de_wr_en       <= take && wr_en;
         de_mem_rd      <= take && mem_rd;
         de_mem_wr      <= take && mem_wr;
         de_halt        <= take && (is_halt || illegal);
         de_branch_kind <= take ? branch_kind : cpu_pkg::OPC_NOP;
      end
   end

   always_ff @(posedge clk) begin
      de_alu_op  <= alu_op;
      de_use_imm <= use_imm;
      de_a       <= rd_a;
      de_b       <= rd_b;
      de_imm     <= imm;
      de_pc_next <= fd_pc_next;
      de_wr_reg  <= wr_reg;
   end

endmodule
`default_nettype wire

// File: design/hazard_unit.sv
// Data hazard detection
// Stalls decode while a source register it reads has a pending write in
// the execute or memory stage. Writeback is covered by register file
// write-through, so it is not compared
`default_nettype none

module hazard_unit (
   input  wire                     use_rs,
   input  wire                     use_rt,
   input  wire cpu_pkg::reg_idx_t  rs,
   input  wire cpu_pkg::reg_idx_t  rt,
   input  wire                     de_valid,
   input  wire                     de_wr_en,
   input  wire cpu_pkg::reg_idx_t  de_wr_reg,
   input  wire                     em_valid,
   input  wire                     em_wr_en,
   input  wire cpu_pkg::reg_idx_t  em_wr_reg,
   output logic                    stall
);

   logic ex_pend;
   logic mem_pend;
   logic rs_hit;
   logic rt_hit;

   // Only valid slots that really write count
   assign ex_pend  = de_valid && de_wr_en;
   assign mem_pend = em_valid && em_wr_en;

   assign rs_hit = use_rs && ((ex_pend && de_wr_reg == rs) || (mem_pend && em_wr_reg == rs));
   assign rt_hit = use_rt && ((ex_pend && de_wr_reg == rt) || (mem_pend && em_wr_reg == rt));

   assign stall = rs_hit || rt_hit;

endmodule
`default_nettype wire

// File: design/execute.sv
// Execute stage
// ALU on A and B or the immediate, branch and jump resolution with the
// redirect back to fetch, and the execute/memory register
`default_nettype none

module execute (
   input  wire                     clk,
   input  wire                     arst_n,
   input  wire                     de_valid,
   input  wire cpu_pkg::alu_op_e   de_alu_op,
   input  wire                     de_use_imm,
   input  wire cpu_pkg::word_t     de_a,
   input  wire cpu_pkg::word_t     de_b,
   input  wire cpu_pkg::word_t     de_imm,
   input  wire cpu_pkg::word_t     de_pc_next,
   input  wire                     de_wr_en,
   input  wire cpu_pkg::reg_idx_t  de_wr_reg,
   input  wire                     de_mem_rd,
   input  wire                     de_mem_wr,
   input  wire cpu_pkg::opcode_e   de_branch_kind,
   input  wire                     de_halt,
   output logic                    redirect,
   output cpu_pkg::word_t          redirect_pc,
   output logic                    em_valid,
   output cpu_pkg::word_t          em_result,
   output cpu_pkg::word_t          em_store_data,
   output logic                    em_mem_rd,
   output logic                    em_mem_wr,
   output logic                    em_wr_en,
   output cpu_pkg::reg_idx_t       em_wr_reg,
   output logic                    em_halt
);

   cpu_pkg::word_t op_b;
   cpu_pkg::word_t result;
   logic           taken;

   assign op_b = de_use_imm ? de_imm : de_b;

   always_comb begin
      case (de_alu_op)
         cpu_pkg::ALU_ADD: result = de_a + op_b;
         cpu_pkg::ALU_SUB: result = de_a - op_b;
         cpu_pkg::ALU_AND: result = de_a & op_b;
         cpu_pkg::ALU_XOR: result = de_a ^ op_b;
         default:          result = de_a;
      endcase
   end

   // Conditional branches test rs against zero
   always_comb begin
      case (de_branch_kind)
         cpu_pkg::OPC_BEQZ: taken = (de_a == '0);
         cpu_pkg::OPC_BNEZ: taken = (de_a != '0);
         cpu_pkg::OPC_J:    taken = 1'b1;
         default:           taken = 1'b0;
      endcase
   end

   // Byte offset from the following instruction
   assign redirect    = de_valid && taken;
   assign redirect_pc = de_pc_next + de_imm;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         em_valid  <= 1'b0;
         em_mem_rd <= 1'b0;
         em_mem_wr <= 1'b0;
         em_wr_en  <= 1'b0;
         em_halt   <= 1'b0;
      end else begin
         em_valid  <= de_valid;
         em_mem_rd <= de_mem_rd;
         em_mem_wr <= de_mem_wr;
         em_wr_en  <= de_wr_en;
         em_halt   <= de_halt;
      end
   end

   always_ff @(posedge clk) begin
      em_result     <= result;
      em_store_data <= de_b;
      em_wr_reg     <= de_wr_reg;
   end

endmodule
`default_nettype wire

// File: design/memory.sv
// Memory stage
// Word-addressed data memory, load or ALU result selection and the
// memory/writeback register
`default_nettype none
`include "cpu_params.svh"

module memory (
   input  wire                     clk,
   input  wire                     arst_n,
   input  wire                     em_valid,
   input  wire cpu_pkg::word_t     em_result,
   input  wire cpu_pkg::word_t     em_store_data,
   input  wire                     em_mem_rd,
   input  wire                     em_mem_wr,
   input  wire                     em_wr_en,
   input  wire cpu_pkg::reg_idx_t  em_wr_reg,
   input  wire                     em_halt,
   output logic                    mw_valid,
   output logic                    mw_wr_en,
   output cpu_pkg::reg_idx_t       mw_wr_reg,
   output cpu_pkg::word_t          mw_data,
   output logic                    mw_halt
);

   localparam int DMEM_AW = $clog2(`CPU_DMEM_DEPTH);

   cpu_pkg::word_t dmem [`CPU_DMEM_DEPTH];
   cpu_pkg::word_t rd_data;

   // Byte address, bit 0 ignored
   assign rd_data = dmem[em_result[DMEM_AW:1]];

   always_ff @(posedge clk) begin
      if (em_valid && em_mem_wr) begin
         dmem[em_result[DMEM_AW:1]] <= em_store_data;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         mw_valid <= 1'b0;
         mw_wr_en <= 1'b0;
         mw_halt  <= 1'b0;
      end else begin
         mw_valid <= em_valid;
         mw_wr_en <= em_wr_en;
         mw_halt  <= em_halt;
      end
   end

   always_ff @(posedge clk) begin
      mw_wr_reg <= em_wr_reg;
      mw_data   <= em_mem_rd ? rd_data : em_result;
   end

endmodule
`default_nettype wire

// File: design/cpu_top.sv
// Five-stage pipelined 16-bit CPU
// Fetch, decode, execute and memory stages with stall-based hazard
// handling. Writeback goes straight from the memory/writeback register
// into the register file and out on the observation port
`default_nettype none
`include "cpu_params.svh"

module cpu_top (
   input  wire                                 clk,
   input  wire                                 arst_n,
   input  wire                                 run,
   input  wire                                 load_en,
   input  wire [$clog2(`CPU_IMEM_DEPTH)-1:0]   load_addr,
   input  wire cpu_pkg::word_t                 load_data,
   output logic                                wb_valid,
   output cpu_pkg::reg_idx_t                   wb_reg,
   output cpu_pkg::word_t                      wb_data,
   output logic                                halted,
   output logic                                err
);

   // Fetch/decode
   logic              fd_valid;
   cpu_pkg::word_t    fd_instr;
   cpu_pkg::word_t    fd_pc_next;

   // Hazard and control flow
   cpu_pkg::reg_idx_t rs;
   cpu_pkg::reg_idx_t rt;
   logic              use_rs;
   logic              use_rt;
   logic              stall;
   logic              halt_seen;
   logic              redirect;
   cpu_pkg::word_t    redirect_pc;

   // Decode/execute
   logic              de_valid;
   cpu_pkg::alu_op_e  de_alu_op;
   logic              de_use_imm;
   cpu_pkg::word_t    de_a;
   cpu_pkg::word_t    de_b;
   cpu_pkg::word_t    de_imm;
   cpu_pkg::word_t    de_pc_next;
   logic              de_wr_en;
   cpu_pkg::reg_idx_t de_wr_reg;
   logic              de_mem_rd;
   logic              de_mem_wr;
   cpu_pkg::opcode_e  de_branch_kind;
   logic              de_halt;

   // Execute/memory
   logic              em_valid;
   cpu_pkg::word_t    em_result;
   cpu_pkg::word_t    em_store_data;
   logic              em_mem_rd;
   logic              em_mem_wr;
   logic              em_wr_en;
   cpu_pkg::reg_idx_t em_wr_reg;
   logic              em_halt;

   // Memory/writeback
   logic              mw_valid;
   logic              mw_wr_en;
   cpu_pkg::reg_idx_t mw_wr_reg;
   cpu_pkg::word_t    mw_data;
   logic              mw_halt;

   fetch i_fetch (
      .clk(clk), .arst_n(arst_n), .run(run),
      .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
      .stall(stall), .halt_seen(halt_seen),
      .redirect(redirect), .redirect_pc(redirect_pc),
      .fd_valid(fd_valid), .fd_instr(fd_instr), .fd_pc_next(fd_pc_next)
   );

   decode i_decode (
      .clk(clk), .arst_n(arst_n), .redirect(redirect), .stall(stall),
      .fd_valid(fd_valid), .fd_instr(fd_instr), .fd_pc_next(fd_pc_next),
      .wb_en(wb_valid), .wb_reg(mw_wr_reg), .wb_data(mw_data),
      .rs(rs), .rt(rt), .use_rs(use_rs), .use_rt(use_rt),
      .halt_seen(halt_seen), .err(err),
      .de_valid(de_valid), .de_alu_op(de_alu_op), .de_use_imm(de_use_imm),
      .de_a(de_a), .de_b(de_b), .de_imm(de_imm), .de_pc_next(de_pc_next),
      .de_wr_en(de_wr_en), .de_wr_reg(de_wr_reg),
      .de_mem_rd(de_mem_rd), .de_mem_wr(de_mem_wr),
      .de_branch_kind(de_branch_kind), .de_halt(de_halt)
   );

   hazard_unit i_hazard_unit (
      .use_rs(use_rs), .use_rt(use_rt), .rs(rs), .rt(rt),
      .de_valid(de_valid), .de_wr_en(de_wr_en), .de_wr_reg(de_wr_reg),
      .em_valid(em_valid), .em_wr_en(em_wr_en), .em_wr_reg(em_wr_reg),
      .stall(stall)
   );

   execute i_execute (
      .clk(clk), .arst_n(arst_n),
      .de_valid(de_valid), .de_alu_op(de_alu_op), .de_use_imm(de_use_imm),
      .de_a(de_a), .de_b(de_b), .de_imm(de_imm), .de_pc_next(de_pc_next),
      .de_wr_en(de_wr_en), .de_wr_reg(de_wr_reg),
      .de_mem_rd(de_mem_rd), .de_mem_wr(de_mem_wr),
      .de_branch_kind(de_branch_kind), .de_halt(de_halt),
      .redirect(redirect), .redirect_pc(redirect_pc),
      .em_valid(em_valid), .em_result(em_result), .em_store_data(em_store_data),
      .em_mem_rd(em_mem_rd), .em_mem_wr(em_mem_wr),
      .em_wr_en(em_wr_en), .em_wr_reg(em_wr_reg), .em_halt(em_halt)
   );

   memory i_memory (
      .clk(clk), .arst_n(arst_n),
      .em_valid(em_valid), .em_result(em_result), .em_store_data(em_store_data),
      .em_mem_rd(em_mem_rd), .em_mem_wr(em_mem_wr),
      .em_wr_en(em_wr_en), .em_wr_reg(em_wr_reg), .em_halt(em_halt),
      .mw_valid(mw_valid), .mw_wr_en(mw_wr_en), .mw_wr_reg(mw_wr_reg),
      .mw_data(mw_data), .mw_halt(mw_halt)
   );

   assign wb_valid = mw_valid && mw_wr_en;
   assign wb_reg   = mw_wr_reg;
   assign wb_data  = mw_data;

   // Set once the halting instruction reaches writeback
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         halted <= 1'b0;
      end else if (mw_valid && mw_halt) begin
         halted <= 1'b1;
      end
   end

endmodule
`default_nettype wire

// File: verif/cpu_tb.sv
// Testbench for the five-stage pipelined CPU
// Reads programs and expected writebacks from the pattern file, loads each
// program through the load port, runs it and checks every writeback in
// program order, then the halted and err state at the end of the program
`default_nettype none
`include "cpu_params.svh"

module cpu_tb;

   localparam int IMEM_AW = $clog2(`CPU_IMEM_DEPTH);

   logic               clk;
   logic               arst_n;
   logic               run;
   logic               load_en;
   logic [IMEM_AW-1:0] load_addr;
   cpu_pkg::word_t     load_data;
   logic               wb_valid;
   cpu_pkg::reg_idx_t  wb_reg;
   cpu_pkg::word_t     wb_data;
   logic               halted;
   logic               err;

   // Pattern records, each tagged with its program number
   int                 p_prog [$];
   logic [IMEM_AW-1:0] p_addr [$];
   cpu_pkg::word_t     p_word [$];
   int                 w_prog [$];
   cpu_pkg::reg_idx_t  w_reg [$];
   cpu_pkg::word_t     w_data [$];
   logic               e_err [$];

   int                 w_next = 0;
   int                 limit_cycles = 0;

   cpu_top i_cpu_top (
      .clk(clk), .arst_n(arst_n), .run(run),
      .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
      .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data),
      .halted(halted), .err(err)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic stop_on_error(input string why);
      $display("%s", why);
      $display("sim failed");
      $fatal(1);
   endtask

   task automatic read_patterns();
      int                 fd;
      int                 n;
      int                 c;
      int                 prog;
      logic [7:0]         kind;
      logic [IMEM_AW-1:0] rec_addr;
      cpu_pkg::word_t     rec_word;
      cpu_pkg::reg_idx_t  rec_reg;
      logic               rec_err;
      fd = $fopen("verif/cpu_patterns.txt", "r");
      if (fd == 0) begin
         stop_on_error("cannot open the pattern file verif/cpu_patterns.txt");
      end
      prog = 0;
      n = $fscanf(fd, " %c", kind);
      while (n == 1) begin
         case (kind)
            "#": begin
               // Comment runs to the end of the line
               c = 0;
               while (c != 10 && c != -1) begin
                  c = $fgetc(fd);
               end
            end
            "P": begin
               n = $fscanf(fd, "%h %h", rec_addr, rec_word);
               if (n != 2) begin
                  stop_on_error("malformed program word record in the pattern file");
               end
               p_prog.push_back(prog);
               p_addr.push_back(rec_addr);
               p_word.push_back(rec_word);
            end
            "W": begin
               n = $fscanf(fd, "%h %h", rec_reg, rec_word);
               if (n != 2) begin
                  stop_on_error("malformed writeback record in the pattern file");
               end
               w_prog.push_back(prog);
               w_reg.push_back(rec_reg);
               w_data.push_back(rec_word);
            end
            "E": begin
               n = $fscanf(fd, "%d", rec_err);
               e_err.push_back(rec_err);
               prog++;
            end
            default: begin
               stop_on_error($sformatf("unknown record kind %c in the pattern file", kind));
            end
         endcase
         n = $fscanf(fd, " %c", kind);
      end
      $fclose(fd);
   endtask

   function automatic int count_pending(input int prog);
      int i;
      int n;
      n = 0;
      for (i = w_next; i < w_reg.size(); i++) begin
         if (w_prog[i] == prog) begin
            n++;
         end
      end
      return n;
   endfunction

   task automatic check_wb(input cpu_pkg::reg_idx_t exp_reg, input cpu_pkg::word_t exp_data);
      if (wb_reg !== exp_reg) begin
         stop_on_error($sformatf("[ERROR] t=%0t wb_reg expected %0d got %0d",
                                 $time, exp_reg, wb_reg));
      end else if (wb_data !== exp_data) begin
         stop_on_error($sformatf("[ERROR] t=%0t wb_data expected %h got %h",
                                 $time, exp_data, wb_data));
      end
   endtask

   task automatic check_end(input logic exp_err, input int remaining);
      if (remaining != 0) begin
         stop_on_error($sformatf("core halted with %0d expected writebacks missing", remaining));
      end else if (err !== exp_err) begin
         stop_on_error($sformatf("[ERROR] t=%0t err expected %0b got %0b",
                                 $time, exp_err, err));
      end
   endtask

   // Two cycles of reset with the core stopped
   task automatic reset_core();
      @(posedge clk);
      #2;
      arst_n = 1'b0;
      run    = 1'b0;
      repeat (2) @(posedge clk);
      #2;
      arst_n = 1'b1;
   endtask

   task automatic load_program(input int prog);
      foreach (p_word[i]) begin
         if (p_prog[i] == prog) begin
            load_en   = 1'b1;
            load_addr = p_addr[i];
            load_data = p_word[i];
            @(posedge clk);
            #2;
         end
      end
      load_en = 1'b0;
   endtask

   task automatic run_program(input int prog);
      bit done;
      reset_core();
      load_program(prog);
      run  = 1'b1;
      done = 1'b0;
      while (!done) begin
         @(negedge clk);
         if (wb_valid === 1'b1) begin
            if (w_next >= w_reg.size() || w_prog[w_next] != prog) begin
               stop_on_error($sformatf("program %0d wrote r%0d = %h with no writeback expected",
                                       prog, wb_reg, wb_data));
            end else begin
               check_wb(w_reg[w_next], w_data[w_next]);
               w_next++;
            end
         end
         done = (halted === 1'b1);
      end
      check_end(e_err[prog], count_pending(prog));
      // Pipeline must stay quiet once halted
      repeat (4) begin
         @(negedge clk);
         if (wb_valid !== 1'b0) begin
            stop_on_error($sformatf("program %0d wrote back after the core halted", prog));
         end
      end
   endtask

   initial begin : main
      int prog;
      arst_n    = 1'b0;
      run       = 1'b0;
      load_en   = 1'b0;
      load_addr = '0;
      load_data = '0;
      read_patterns();
      limit_cycles = p_word.size() * 8 + 200;
      for (prog = 0; prog < e_err.size(); prog++) begin
         run_program(prog);
      end
      if (e_err.size() > 0 && w_next == w_reg.size()) begin
         $display("sim passed");
         $finish;
      end else begin
         stop_on_error("pattern file held no complete program or unused writebacks");
      end
   end

   // Limit scales with the number of program words
   initial begin : watchdog
      wait (limit_cycles > 0);
      repeat (limit_cycles) @(posedge clk);
      stop_on_error($sformatf("timeout, programs not finished after %0d cycles", limit_cycles));
   end

endmodule
`default_nettype wire

// File: verif/cpu_patterns.txt
# P <word index hex> <instruction hex> | W <reg> <data hex> | E <expected err>
# Records of one program close with its E line; text after # is ignored
# Program 1: ALU ops, store and load, load-use, branches, jump, HALT
P 00 C800   # sub  r0, r0, r0
P 01 4025   # addi r1, r0, 5
P 02 405D   # addi r2, r0, -3
P 03 C14C   # add  r3, r1, r2
P 04 C950   # sub  r4, r1, r2
P 05 D234   # and  r5, r2, r1
P 06 DA98   # xor  r6, r2, r4
P 07 80C4   # st   r6, 4(r0)
P 08 88E4   # ld   r7, 4(r0)
P 09 C764   # add  r1, r7, r3
P 0A 6004   # beqz r0, +4 taken
P 0B 4041   # flushed
P 0C 4061   # flushed
P 0D 6804   # bnez r0, +4 falls through
P 0E 4047   # addi r2, r0, 7
P 0F 2004   # j    +4
P 10 4069   # flushed
P 11 4089   # flushed
P 12 6A02   # bnez r2, +2 taken
P 13 40A1   # flushed
P 14 0000   # halt
P 15 40C1   # never reached
W 0 0000
W 1 0005
W 2 FFFD
W 3 0002
W 4 0008
W 5 0005
W 6 FFF5
W 7 FFF5
W 1 FFF7
W 2 0007
E 0
# Program 2: dependent chain, load-use, then an illegal opcode
P 00 DB6C   # xor  r3, r3, r3
P 01 438F   # addi r4, r3, 15
P 02 C494   # add  r5, r4, r4
P 03 83A6   # st   r5, 6(r3)
P 04 8BC6   # ld   r6, 6(r3)
P 05 CBDC   # sub  r7, r3, r6
P 06 F800   # illegal opcode 11111
P 07 4321   # never reached
P 08 0000   # halt
W 3 0000
W 4 000F
W 5 001E
W 6 001E
W 7 FFE2
E 1

// File: verilog.f
+incdir+design
design/cpu_pkg.sv
design/fetch.sv
design/decode.sv
design/hazard_unit.sv
design/execute.sv
design/memory.sv
design/cpu_top.sv
verif/cpu_tb.sv

// File: Makefile
# Verilator build and run of the pipelined CPU testbench

.PHONY: sim clean

sim:
	verilator --binary --x-initial 0 --top-module cpu_tb -f verilog.f -o cpu_sim
	./obj_dir/cpu_sim

clean:
	rm -rf obj_dir
